/* compile.f */
source/armPkg.sv
source/hazardIf.sv
source/alu.sv
source/decoder.sv
source/regFile.sv
source/wordRam.sv
source/hazard.sv
source/datapath.sv
source/armCore.sv
verification/hazard_props.sv
verification/armCoreTb.sv

/* run.sh */
#!/bin/sh
# Build the armCore testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module armCoreTb -f compile.f

# Keep going on a simulator error so the log is still shown
status=0
./obj_dir/VarmCoreTb > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
echo "Simulation finished without failure"

/* verification/armCoreTb.sv */
`timescale 1ns/1ps

module armCoreTb;

  localparam int numPrograms = 20;
  localparam int progLen     = 40;
  localparam int memWords    = 256;
  localparam int resetCycles = 8;
  localparam int clkPeriod   = 8;
  // Random body follows eight MOVs, the base MOV and four STRs
  localparam int bodyStart   = 13;
  localparam int haltLimit   = progLen * 20;
  localparam int timeoutNs   = numPrograms * progLen * 20 * clkPeriod;

  localparam armPkg::opT aluOpList [5] = '{armPkg::opAdd, armPkg::opSub, armPkg::opAnd,
                                           armPkg::opOrr, armPkg::opMov};

  // One expected retirement
  typedef struct packed {
    logic [31:0] pc;
    logic        regWrite;
    logic [3:0]  rd;
    logic [31:0] result;
    logic        memWrite;
    logic [31:0] addr;
  } recT;

  logic        clk = 1'b0;
  logic        rstN = 1'b0;
  logic        progWe = 1'b0;
  logic [31:0] progAddr = '0;
  logic [31:0] progData = '0;
  logic        retireReady = 1'b0;
  logic        retireValid;
  logic [31:0] retirePc;
  logic        retireRegWrite;
  logic [3:0]  retireRd;
  logic [31:0] retireResult;
  logic        retireMemWrite;
  logic [31:0] retireAddr;
  logic        halted;
  logic        prevRstN;

  logic [31:0] prog [progLen];
  logic [31:0] regModel [16];
  logic [31:0] memModel [memWords];
  recT         expQ [$];
  int          valueErrors = 0;
  int          recordErrors = 0;
  int          flowErrors = 0;

  armCore #(.imemWords(memWords), .dmemWords(memWords)) DUT (
    .clk           (clk),
    .rstN          (rstN),
    .progWe        (progWe),
    .progAddr      (progAddr),
    .progData      (progData),
    .retireValid   (retireValid),
    .retireReady   (retireReady),
    .retirePc      (retirePc),
    .retireRegWrite(retireRegWrite),
    .retireRd      (retireRd),
    .retireResult  (retireResult),
    .retireMemWrite(retireMemWrite),
    .retireAddr    (retireAddr),
    .halted        (halted)
  );

  always #(clkPeriod / 2) clk = ~clk;

  function automatic int randBelow(int n);
    return int'($urandom % n);
  endfunction

  function automatic logic [31:0] encode(logic [3:0] op, logic [3:0] rd, logic [3:0] rn,
                                         logic [3:0] rm, logic immSel, logic [11:0] imm);
    return {op, rd, rn, rm, immSel, 3'b000, imm};
  endfunction

  // Forward distance from idx + 1, target never beyond the HALT
  function automatic logic [11:0] forwardOffset(int idx);
    int room;
    room = progLen - 2 - idx;
    if (room > 4) begin
      room = 4;
    end
    return 12'(randBelow(room + 1));
  endfunction

  function automatic void genProgram();
    int         i;
    int         sel;
    logic [3:0] rd;
    logic [3:0] rn;
    logic [3:0] rm;
    logic       immSel;
    // Some registers start at zero so BEQZ goes both ways
    for (i = 0; i < 8; i++) begin
      prog[i] = encode(armPkg::opMov, 4'(i), 4'd0, 4'd0, 1'b1,
                       (randBelow(3) == 0) ? 12'd0 : 12'(randBelow(4096)));
    end
    // r8 is the base for every load and store
    prog[8] = encode(armPkg::opMov, 4'd8, 4'd0, 4'd0, 1'b1, 12'(randBelow(64)));
    // Fill all four data words, so every later load has a known source
    for (i = 0; i < 4; i++) begin
      prog[9 + i] = encode(armPkg::opStr, 4'(i), 4'd8, 4'd0, 1'b1, 12'(i));
    end
    for (i = bodyStart; i < progLen - 1; i++) begin
      sel    = randBelow(20);
      rd     = 4'(randBelow(8));
      rn     = 4'(randBelow(8));
      rm     = 4'(randBelow(8));
      immSel = 1'(randBelow(2));
      if (sel < 10) begin
        prog[i] = encode(aluOpList[randBelow(5)], rd, rn, rm, immSel, 12'(randBelow(16)));
      end else if (sel < 13) begin
        prog[i] = encode(armPkg::opLdr, rd, 4'd8, 4'd0, 1'b1, 12'(randBelow(4)));
      end else if (sel < 15) begin
        prog[i] = encode(armPkg::opStr, rd, 4'd8, 4'd0, 1'b1, 12'(randBelow(4)));
      end else if (sel < 18) begin
        prog[i] = encode(armPkg::opBeqz, 4'd0, rn, 4'd0, 1'b0, forwardOffset(i));
      end else if (sel < 19) begin
        prog[i] = encode(armPkg::opB, 4'd0, 4'd0, 4'd0, 1'b0, forwardOffset(i));
      end else begin
        // Clears rd, zero tests get likely
        prog[i] = encode(armPkg::opAnd, rd, rn, 4'd0, 1'b1, 12'd0);
      end
    end
    prog[progLen - 1] = encode(armPkg::opHalt, 4'd0, 4'd0, 4'd0, 1'b0, 12'd0);
  endfunction

  // ISA model, one record per instruction on the architectural path
  function automatic void refExecute();
    int          pc;
    int          pcNext;
    int          steps;
    logic [31:0] ins;
    logic [31:0] imm;
    logic [31:0] simm;
    logic [31:0] opB;
    logic [3:0]  rd;
    logic [3:0]  rn;
    armPkg::opT  op;
    recT         rec;
    logic        done;
    expQ.delete();
    pc    = 0;
    steps = 0;
    done  = 1'b0;
    // Branches only go forward, so progLen steps always reach HALT
    while (!done && steps < progLen) begin
      ins     = prog[pc];
      op      = armPkg::opT'(ins[31:28]);
      rd      = ins[27:24];
      rn      = ins[23:20];
      imm     = {20'd0, ins[11:0]};
      simm    = {{20{ins[11]}}, ins[11:0]};
      opB     = ins[15] ? imm : regModel[ins[19:16]];
      rec     = '0;
      rec.pc  = 32'(pc);
      rec.rd  = rd;
      pcNext  = pc + 1;
      case (op)
        armPkg::opAdd: rec.result = regModel[rn] + opB;
        armPkg::opSub: rec.result = regModel[rn] - opB;
        armPkg::opAnd: rec.result = regModel[rn] & opB;
        armPkg::opOrr: rec.result = regModel[rn] | opB;
        armPkg::opMov: rec.result = opB;
        armPkg::opLdr: begin
          rec.addr   = regModel[rn] + imm;
          rec.result = memModel[rec.addr % memWords];
        end
        armPkg::opStr: begin
          rec.addr                    = regModel[rn] + imm;
          rec.memWrite                = 1'b1;
          rec.result                  = regModel[rd];
          memModel[rec.addr % memWords] = regModel[rd];
        end
        armPkg::opBeqz: begin
          if (regModel[rn] == 32'd0) begin
            pcNext = pc + 1 + int'(simm);
          end
        end
        armPkg::opB: pcNext = pc + 1 + int'(simm);
        default: done = 1'b1;
      endcase
      rec.regWrite = op inside {armPkg::opAdd, armPkg::opSub, armPkg::opAnd,
                                armPkg::opOrr, armPkg::opMov, armPkg::opLdr};
      if (rec.regWrite) begin
        regModel[rd] = rec.result;
      end
      expQ.push_back(rec);
      pc = pcNext;
      steps++;
    end
  endfunction

  // Reset covers the whole load and at least resetCycles
  task automatic loadProgram();
    int i;
    for (i = 0; i < progLen || i < resetCycles; i++) begin
      @(negedge clk);
      progWe   = (i < progLen);
      progAddr = 32'(i);
      progData = (i < progLen) ? prog[i] : 32'd0;
    end
    @(negedge clk);
    progWe = 1'b0;
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      valueErrors++;
      $display("Fail %s: expected %h, got %h at %0t", name, expected, actual, $time);
    end
  endtask

  // Random back-pressure, roughly one cycle in four held off
  always @(negedge clk) begin
    retireReady = (randBelow(4) != 0);
  end

  // Compare every accepted record with the next expected one
  always @(posedge clk) begin
    recT want;
    // First edge after reset, the core must be idle
    if (rstN && !prevRstN) begin
      checkValue("retireValid", 32'd0, 32'(retireValid));
      checkValue("halted", 32'd0, 32'(halted));
    end
    prevRstN = rstN;
    if (rstN && retireValid && retireReady) begin
      if (halted) begin
        recordErrors++;
        $display("Record at pc %h retired after HALT", retirePc);
      end else if (expQ.size() == 0) begin
        recordErrors++;
        $display("Extra record at pc %h, none was expected", retirePc);
      end else begin
        want = expQ.pop_front();
        checkValue("retirePc", want.pc, retirePc);
        checkValue("retireRegWrite", 32'(want.regWrite), 32'(retireRegWrite));
        checkValue("retireRd", 32'(want.rd), 32'(retireRd));
        checkValue("retireResult", want.result, retireResult);
        checkValue("retireMemWrite", 32'(want.memWrite), 32'(retireMemWrite));
        checkValue("retireAddr", want.addr, retireAddr);
      end
    end
  end

  initial begin
    int p;
    int cycles;
    void'($urandom(32'h268a));
    for (p = 0; p < numPrograms; p++) begin
      @(negedge clk);
      rstN = 1'b0;
      genProgram();
      refExecute();
      loadProgram();
      rstN = 1'b1;
      cycles = 0;
      while (!halted && cycles < haltLimit) begin
        @(negedge clk);
        cycles++;
      end
      // Idle cycles catch anything retiring after HALT
      repeat (8) @(negedge clk);
      if (!halted) begin
        flowErrors++;
        $display("Program %0d never halted, %0d records missing", p, expQ.size());
      end else if (expQ.size() != 0) begin
        flowErrors++;
        $display("Program %0d halted with %0d records missing", p, expQ.size());
      end
    end
    $display("Errors: %0d value, %0d record, %0d flow",
             valueErrors, recordErrors, flowErrors);
    if (valueErrors + recordErrors + flowErrors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog, bound by the length of all programs
  initial begin
    #(timeoutNs);
    $display("Watchdog expired after %0d ns, run stopped", timeoutNs);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* verification/hazard_props.sv */
`timescale 1ns/1ps

module hazardProps (
  input logic       clk,
  input logic       rstN,
  input logic       retireStall,
  input logic       stallF,
  input logic       stallD,
  input logic       stallE,
  input logic       stallM,
  input logic       stallW,
  input logic       flushD,
  input logic       flushE,
  input logic [1:0] forwardAE
);

  // Decode never holds while fetch runs on
  stallDImpliesF: assert property (@(posedge clk) disable iff (!rstN)
    stallD |-> stallF)
    else $error("stallD high while stallF low");

  // Back-pressure freezes the whole pipe and blocks every flush
  retireFreeze: assert property (@(posedge clk) disable iff (!rstN)
    retireStall |-> (stallF & stallD & stallE & stallM & stallW & ~flushD & ~flushE))
    else $error("retireStall without a full freeze");

  // Encoding 11 is never used for the A operand
  fwdAEncoding: assert property (@(posedge clk) disable iff (!rstN)
    forwardAE != 2'b11)
    else $error("forwardAE took the unused encoding");

  // Empty pipe right out of reset, nothing to hold
  idleAfterReset: assert property (@(posedge clk)
    $rose(rstN) |-> !(stallF | stallD | stallE | stallM | stallW))
    else $error("stall active on the first cycle after reset");

endmodule

bind hazard hazardProps hazardPropsI (
  .clk        (clk),
  .rstN       (rstN),
  .retireStall(hz.retireStall),
  .stallF     (hz.stallF),
  .stallD     (hz.stallD),
  .stallE     (hz.stallE),
  .stallM     (hz.stallM),
  .stallW     (hz.stallW),
  .flushD     (hz.flushD),
  .flushE     (hz.flushE),
  .forwardAE  (hz.forwardAE)
);

/* source/armCore.sv */
`timescale 1ns/1ps

module armCore #(
  parameter int imemWords = 256,
  parameter int dmemWords = 256
) (
  input  logic           clk,
  input  logic           rstN,
  input  logic           progWe,
  input  armPkg::wordT   progAddr,
  input  armPkg::wordT   progData,
  output logic           retireValid,
  input  logic           retireReady,
  output armPkg::wordT   retirePc,
  output logic           retireRegWrite,
  output armPkg::regIdxT retireRd,
  output armPkg::wordT   retireResult,
  output logic           retireMemWrite,
  output armPkg::wordT   retireAddr,
  output logic           halted
);

  hazardIf hzBus ();

  armPkg::wordT imemAddr, imemData;
  armPkg::wordT dmemAddr, dmemWdata, dmemRdata;
  logic         dmemWe;

  datapath datapathI (
    .clk           (clk),
    .rstN          (rstN),
    .imemAddr      (imemAddr),
    .imemData      (imemData),
    .dmemAddr      (dmemAddr),
    .dmemWe        (dmemWe),
    .dmemWdata     (dmemWdata),
    .dmemRdata     (dmemRdata),
    .hz            (hzBus.dp),
    .retireValid   (retireValid),
    .retireReady   (retireReady),
    .retirePc      (retirePc),
    .retireRegWrite(retireRegWrite),
    .retireRd      (retireRd),
    .retireResult  (retireResult),
    .retireMemWrite(retireMemWrite),
    .retireAddr    (retireAddr),
    .halted        (halted)
  );

  hazard hazardI (
    .clk (clk),
    .rstN(rstN),
    .hz  (hzBus.hz)
  );

  // Program load port writes the instruction RAM
  wordRam #(.words(imemWords)) imemI (
    .clk  (clk),
    .we   (progWe),
    .waddr(progAddr),
    .wdata(progData),
    .raddr(imemAddr),
    .rdata(imemData)
  );

  // Data RAM, one address for read and write
  wordRam #(.words(dmemWords)) dmemI (
    .clk  (clk),
    .we   (dmemWe),
    .waddr(dmemAddr),
    .wdata(dmemWdata),
    .raddr(dmemAddr),
    .rdata(dmemRdata)
  );

endmodule

/* source/datapath.sv */
`timescale 1ns/1ps

module datapath (
  input  logic           clk,
  input  logic           rstN,
  output armPkg::wordT   imemAddr,
  input  armPkg::wordT   imemData,
  output armPkg::wordT   dmemAddr,
  output logic           dmemWe,
  output armPkg::wordT   dmemWdata,
  input  armPkg::wordT   dmemRdata,
  hazardIf.dp            hz,
  output logic           retireValid,
  input  logic           retireReady,
  output armPkg::wordT   retirePc,
  output logic           retireRegWrite,
  output armPkg::regIdxT retireRd,
  output armPkg::wordT   retireResult,
  output logic           retireMemWrite,
  output armPkg::wordT   retireAddr,
  output logic           halted
);

  // Fetch
  armPkg::wordT   pcF;
  logic           fetchStopped;
  // Decode
  logic           validD;
  armPkg::wordT   instrD, pcD, immD, rd1D, rd2D;
  armPkg::ctrlT   ctrlD;
  armPkg::regIdxT rdD, rnD, src2D;
  // Execute
  logic           validE;
  logic           zeroE;
  armPkg::ctrlT   ctrlE;
  armPkg::regIdxT rdE, rnE, src2E;
  armPkg::wordT   immE, rd1E, rd2E, pcE;
  armPkg::wordT   srcAE, src2ValE, srcBE, aluOutE, branchTargetE;
  // Memory
  logic           validM;
  armPkg::ctrlT   ctrlM;
  armPkg::regIdxT rdM;
  armPkg::wordT   aluOutM, writeDataM, pcM, resultM;
  // Writeback
  logic           validW;
  armPkg::ctrlT   ctrlW;
  armPkg::regIdxT rdW;
  armPkg::wordT   resultW, addrW, pcW;

  // PC steps by one word, or jumps on a taken branch in execute
  assign imemAddr = pcF;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcF <= '0;
    end else if (!hz.stallF) begin
      pcF <= hz.branchTakenE ? branchTargetE : pcF + 32'd1;
    end
  end

  // Latches once HALT moves on to execute, fetch then only makes bubbles
  always_ff @(posedge clk) begin
    if (!rstN) begin
      fetchStopped <= 1'b0;
    end else if (hz.haltD & ~hz.stallD & ~hz.flushE) begin
      fetchStopped <= 1'b1;
    end
  end

  // Fetch to decode register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validD <= 1'b0;
    end else if (hz.flushD) begin
      validD <= 1'b0;
    end else if (!hz.stallD) begin
      validD <= ~fetchStopped;
    end
  end

  always_ff @(posedge clk) begin
    if (!hz.stallD) begin
      instrD <= imemData;
      pcD    <= pcF;
    end
  end

  decoder decoderI (
    .instr(instrD),
    .ctrl (ctrlD),
    .rd   (rdD),
    .rn   (rnD),
    .src2 (src2D),
    .imm  (immD)
  );

  // Retirement writes the register file
  // A held record rewrites the same value while back-pressured
  regFile regFileI (
    .clk(clk),
    .we (hz.regWriteW),
    .wa (rdW),
    .wd (resultW),
    .ra1(rnD),
    .ra2(src2D),
    .rd1(rd1D),
    .rd2(rd2D)
  );

  // Decode to execute register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validE <= 1'b0;
    end else if (hz.flushE) begin
      validE <= 1'b0;
    end else if (!hz.stallE) begin
      validE <= validD;
    end
  end

  always_ff @(posedge clk) begin
    if (!hz.stallE) begin
      ctrlE <= ctrlD;
      rdE   <= rdD;
      rnE   <= rnD;
      src2E <= src2D;
      immE  <= immD;
      rd1E  <= rd1D;
      rd2E  <= rd2D;
      pcE   <= pcD;
    end
  end

  // Register compares, never true for a bubble
  assign hz.match1EM = validE & ctrlE.readsRn & validM & (rnE == rdM);
  assign hz.match1EW = validE & ctrlE.readsRn & validW & (rnE == rdW);
  assign hz.match2EM = validE & ctrlE.readsSrc2 & validM & (src2E == rdM);
  assign hz.match2EW = validE & ctrlE.readsSrc2 & validW & (src2E == rdW);
  assign hz.match1DE = validD & ctrlD.readsRn & validE & (rnD == rdE);
  assign hz.match2DE = validD & ctrlD.readsSrc2 & validE & (src2D == rdE);

  assign hz.regWriteM   = validM & ctrlM.regWrite;
  assign hz.regWriteW   = validW & ctrlW.regWrite;
  assign hz.memToRegE   = validE & ctrlE.memToReg;
  assign hz.haltD       = validD & ctrlD.isHalt;
  assign hz.retireStall = validW & ~retireReady;

  // Forwarded operands
  always_comb begin
    case (hz.forwardAE)
      armPkg::fwdM: srcAE = resultM;
      armPkg::fwdW: srcAE = resultW;
      default:      srcAE = rd1E;
    endcase
    case (hz.forwardBE)
      armPkg::fwdM: src2ValE = resultM;
      armPkg::fwdW: src2ValE = resultW;
      default:      src2ValE = rd2E;
    endcase
  end

  assign srcBE = ctrlE.useImm ? immE : src2ValE;

  alu aluI (
    .a     (srcAE),
    .b     (srcBE),
    .op    (ctrlE.aluOp),
    .y     (aluOutE),
    .isZero(zeroE)
  );

  // Branch offset counts words from the next instruction
  assign branchTargetE   = pcE + 32'd1 + immE;
  assign hz.branchTakenE = validE & (ctrlE.isB | (ctrlE.isBeqz & zeroE));

  // Execute to memory register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validM <= 1'b0;
    end else if (!hz.stallM) begin
      validM <= validE;
    end
  end

  always_ff @(posedge clk) begin
    if (!hz.stallM) begin
      ctrlM      <= ctrlE;
      rdM        <= rdE;
      aluOutM    <= aluOutE;
      writeDataM <= src2ValE;
      pcM        <= pcE;
    end
  end

  // Store commits only on the edge that moves it to writeback
  assign dmemAddr  = aluOutM;
  assign dmemWdata = writeDataM;
  assign dmemWe    = validM & ctrlM.memWrite & ~hz.retireStall;

  // Result is load data, store data or ALU output
  // Zero for instructions with no result
  always_comb begin
    if (ctrlM.memToReg) begin
      resultM = dmemRdata;
    end else if (ctrlM.memWrite) begin
      resultM = writeDataM;
    end else if (ctrlM.regWrite) begin
      resultM = aluOutM;
    end else begin
      resultM = '0;
    end
  end

  // Memory to writeback register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validW <= 1'b0;
    end else if (!hz.stallW) begin
      validW <= validM;
    end
  end

  always_ff @(posedge clk) begin
    if (!hz.stallW) begin
      ctrlW   <= ctrlM;
      rdW     <= rdM;
      resultW <= resultM;
      addrW   <= (ctrlM.memToReg | ctrlM.memWrite) ? aluOutM : '0;
      pcW     <= pcM;
    end
  end

  // Retirement record straight from writeback, stable while stalled
  assign retireValid    = validW;
  assign retirePc       = pcW;
  assign retireRegWrite = ctrlW.regWrite;
  assign retireRd       = rdW;
  assign retireResult   = resultW;
  assign retireMemWrite = ctrlW.memWrite;
  assign retireAddr     = addrW;

  // Set once the HALT record is accepted
  always_ff @(posedge clk) begin
    if (!rstN) begin
      halted <= 1'b0;
    end else if (validW & ctrlW.isHalt & retireReady) begin
      halted <= 1'b1;
    end
  end

endmodule

/* source/hazard.sv */
`timescale 1ns/1ps

module hazard (
  input logic clk,
  input logic rstN,
  hazardIf.hz hz
);

  logic ldrStallD;

  // Operand forwarding, memory stage has priority over writeback
  always_comb begin
    if (hz.match1EM & hz.regWriteM) begin
      hz.forwardAE = armPkg::fwdM;
    end else if (hz.match1EW & hz.regWriteW) begin
      hz.forwardAE = armPkg::fwdW;
    end else begin
      hz.forwardAE = armPkg::fwdNone;
    end

    if (hz.match2EM & hz.regWriteM) begin
      hz.forwardBE = armPkg::fwdM;
    end else if (hz.match2EW & hz.regWriteW) begin
      hz.forwardBE = armPkg::fwdW;
    end else begin
      hz.forwardBE = armPkg::fwdNone;
    end
  end

  // Load result not ready until memory stage
  // Decode waits one cycle, execute gets a bubble
  assign ldrStallD = (hz.match1DE | hz.match2DE) & hz.memToRegE;

  // Fetch holds on load-use or halt in decode
  // A taken branch still redirects the PC
  assign hz.stallF = hz.retireStall | ((ldrStallD | hz.haltD) & ~hz.branchTakenE);
  assign hz.stallD = hz.retireStall | ldrStallD;

  // Back-pressure on retirement freezes the later stages
  assign hz.stallE = hz.retireStall;
  assign hz.stallM = hz.retireStall;
  assign hz.stallW = hz.retireStall;

  // Wrong-path kills after a taken branch
  // Halt in decode drops everything fetched behind it
  // No flush while frozen, so held stages keep their contents
  assign hz.flushD = (hz.branchTakenE | hz.haltD) & ~hz.retireStall;
  assign hz.flushE = (hz.branchTakenE | ldrStallD) & ~hz.retireStall;

endmodule

/* source/wordRam.sv */
`timescale 1ns/1ps

module wordRam #(
  parameter int words = 256
) (
  input  logic         clk,
  input  logic         we,
  input  armPkg::wordT waddr,
  input  armPkg::wordT wdata,
  input  armPkg::wordT raddr,
  output armPkg::wordT rdata
);

  localparam int idxBits = $clog2(words);

  armPkg::wordT       mem [words];
  logic [idxBits-1:0] wIdx;
  logic [idxBits-1:0] rIdx;

  // Word addresses wrap around the array
  assign wIdx = idxBits'(waddr % words);
  assign rIdx = idxBits'(raddr % words);

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wIdx] <= wdata;
    end
  end

  // Combinational read
  assign rdata = mem[rIdx];

endmodule

/* source/regFile.sv */
`timescale 1ns/1ps

module regFile (
  input  logic           clk,
  input  logic           we,
  input  armPkg::regIdxT wa,
  input  armPkg::wordT   wd,
  input  armPkg::regIdxT ra1,
  input  armPkg::regIdxT ra2,
  output armPkg::wordT   rd1,
  output armPkg::wordT   rd2
);

  armPkg::wordT regs [16];

  // Write in the first half of the cycle
  // Decode reads the new value before the next rising edge
  always_ff @(negedge clk) begin
    if (we) begin
      regs[wa] <= wd;
    end
  end

  // Asynchronous read ports
  assign rd1 = regs[ra1];
  assign rd2 = regs[ra2];

endmodule

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder (
  input  armPkg::wordT   instr,
  output armPkg::ctrlT   ctrl,
  output armPkg::regIdxT rd,
  output armPkg::regIdxT rn,
  output armPkg::regIdxT src2,
  output armPkg::wordT   imm
);

  armPkg::opT                  op;
  armPkg::regIdxT              rm;
  logic                        immSel;
  logic [armPkg::immWidth-1:0] immField;

  // Raw fields
  assign op       = armPkg::opT'(instr[armPkg::opMsb:armPkg::opLsb]);
  assign rd       = instr[armPkg::rdMsb:armPkg::rdLsb];
  assign rn       = instr[armPkg::rnMsb:armPkg::rnLsb];
  assign rm       = instr[armPkg::rmMsb:armPkg::rmLsb];
  assign immSel   = instr[armPkg::immSelBit];
  assign immField = instr[armPkg::immMsb:armPkg::immLsb];

  always_comb begin
    // Unknown opcodes fall through as a no-op
    ctrl = '0;
    src2 = rm;
    imm  = {{(32 - armPkg::immWidth){1'b0}}, immField};
    case (op)
      armPkg::opAdd, armPkg::opSub, armPkg::opAnd, armPkg::opOrr: begin
        ctrl.regWrite  = 1'b1;
        ctrl.useImm    = immSel;
        ctrl.readsRn   = 1'b1;
        ctrl.readsSrc2 = ~immSel;
        ctrl.aluOp     = (op == armPkg::opSub) ? armPkg::aluSub :
                         (op == armPkg::opAnd) ? armPkg::aluAnd :
                         (op == armPkg::opOrr) ? armPkg::aluOrr : armPkg::aluAdd;
      end
      armPkg::opMov: begin
        // Second operand passed straight through
        ctrl.regWrite  = 1'b1;
        ctrl.aluOp     = armPkg::aluPass;
        ctrl.useImm    = immSel;
        ctrl.readsSrc2 = ~immSel;
      end
      armPkg::opLdr: begin
        // Address is rn plus offset
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.useImm   = 1'b1;
        ctrl.readsRn  = 1'b1;
      end
      armPkg::opStr: begin
        // Store data comes from rd on the second port
        ctrl.memWrite  = 1'b1;
        ctrl.useImm    = 1'b1;
        ctrl.readsRn   = 1'b1;
        ctrl.readsSrc2 = 1'b1;
        src2           = rd;
      end
      armPkg::opBeqz: begin
        ctrl.isBeqz  = 1'b1;
        ctrl.readsRn = 1'b1;
        imm          = {{(32 - armPkg::immWidth){immField[armPkg::immWidth-1]}}, immField};
      end
      armPkg::opB: begin
        ctrl.isB = 1'b1;
        imm      = {{(32 - armPkg::immWidth){immField[armPkg::immWidth-1]}}, immField};
      end
      armPkg::opHalt: begin
        ctrl.isHalt = 1'b1;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
  input  armPkg::wordT  a,
  input  armPkg::wordT  b,
  input  armPkg::aluOpT op,
  output armPkg::wordT  y,
  output logic          isZero
);

  always_comb begin
    case (op)
      armPkg::aluAdd: begin
        y = a + b;
      end
      armPkg::aluSub: begin
        y = a - b;
      end
      armPkg::aluAnd: begin
        y = a & b;
      end
      armPkg::aluOrr: begin
        y = a | b;
      end
      armPkg::aluPass: begin
        // MOV takes operand b as is
        y = b;
      end
      default: begin
        y = '0;
      end
    endcase
  end

  // Branch condition, looks at the first operand only
  assign isZero = (a == '0);

endmodule

/* source/hazardIf.sv */
`timescale 1ns/1ps

interface hazardIf;

  // Source and destination compares, already valid-qualified
  logic match1EM;
  logic match1EW;
  logic match2EM;
  logic match2EW;
  logic match1DE;
  logic match2DE;

  // Stage status from the datapath
  logic regWriteM;
  logic regWriteW;
  logic memToRegE;
  logic branchTakenE;
  logic haltD;
  logic retireStall;

  // Pipeline control back to the datapath
  armPkg::fwdT forwardAE;
  armPkg::fwdT forwardBE;
  logic        stallF;
  logic        stallD;
  logic        stallE;
  logic        stallM;
  logic        stallW;
  logic        flushD;
  logic        flushE;

  modport dp (
    output match1EM, match1EW, match2EM, match2EW, match1DE, match2DE,
    output regWriteM, regWriteW, memToRegE, branchTakenE, haltD, retireStall,
    input  forwardAE, forwardBE, stallF, stallD, stallE, stallM, stallW, flushD, flushE
  );

  modport hz (
    input  match1EM, match1EW, match2EM, match2EW, match1DE, match2DE,
    input  regWriteM, regWriteW, memToRegE, branchTakenE, haltD, retireStall,
    output forwardAE, forwardBE, stallF, stallD, stallE, stallM, stallW, flushD, flushE
  );

endinterface

/* source/armPkg.sv */
package armPkg;

  // Basic data types
  typedef logic [31:0] wordT;
  typedef logic [3:0]  regIdxT;

  // Opcode held in the top nibble of every instruction
  typedef enum logic [3:0] {
    opAdd  = 4'd0,
    opSub  = 4'd1,
    opAnd  = 4'd2,
    opOrr  = 4'd3,
    opMov  = 4'd4,
    opLdr  = 4'd5,
    opStr  = 4'd6,
    opBeqz = 4'd7,
    opB    = 4'd8,
    opHalt = 4'd9
  } opT;

  // Instruction field positions
  localparam int opMsb     = 31;
  localparam int opLsb     = 28;
  localparam int rdMsb     = 27;
  localparam int rdLsb     = 24;
  localparam int rnMsb     = 23;
  localparam int rnLsb     = 20;
  localparam int rmMsb     = 19;
  localparam int rmLsb     = 16;
  localparam int immSelBit = 15;
  localparam int immMsb    = 11;
  localparam int immLsb    = 0;
  localparam int immWidth  = immMsb - immLsb + 1;

  typedef enum logic [2:0] {
    aluAdd  = 3'd0,
    aluSub  = 3'd1,
    aluAnd  = 3'd2,
    aluOrr  = 3'd3,
    aluPass = 3'd4
  } aluOpT;

  // Decoded control bundle carried down the pipe
  typedef struct packed {
    logic  regWrite;
    logic  memToReg;
    logic  memWrite;
    aluOpT aluOp;
    logic  useImm;
    logic  isBeqz;
    logic  isB;
    logic  isHalt;
    logic  readsRn;
    logic  readsSrc2;
  } ctrlT;

  // Operand source for execute
  typedef enum logic [1:0] {
    fwdNone = 2'b00,
    fwdW    = 2'b01,
    fwdM    = 2'b10
  } fwdT;

endpackage
